// ==== verilog/div_settings.svh ====
`ifndef DIV_SETTINGS_SVH
`define DIV_SETTINGS_SVH

// Width of dividend, divisor, quotient and remainder
`define DIV_WIDTH 16

// Must be wide enough to hold DIV_WIDTH - 1
`define DIV_CNT_WIDTH 4

`endif

// ==== verilog/div_pkg.sv ====
`include "div_settings.svh"

package div_pkg;

    typedef struct packed {
        logic [`DIV_WIDTH-1:0] dividend;
        logic [`DIV_WIDTH-1:0] divisor;
    } div_operands_t;

    typedef struct packed {
        logic [`DIV_WIDTH-1:0] quotient;
        logic [`DIV_WIDTH-1:0] remainder;
    } div_result_t;

    // Shifted as one word during the steps, read as two halves for the result
    typedef union packed {
        logic [2*`DIV_WIDTH-1:0] word;
        struct packed {
            logic [`DIV_WIDTH-1:0] rem;
            logic [`DIV_WIDTH-1:0] quo; // Starts as the dividend
        } f;
    } div_rq_t;

    typedef enum logic [1:0] {
        op_hold       = 2'b00,
        op_load       = 2'b01,
        op_shift_sub  = 2'b10,
        op_shift_keep = 2'b11
    } div_op_t;

endpackage

// ==== verilog/div_control.sv ====
`timescale 1ns/1ns

module div_control import div_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    src_valid,
    input  logic    dest_ready,
    input  logic    borrow,
    input  logic    last_step,
    output logic    src_ready,
    output logic    dest_valid,
    output logic    count_clear,
    output logic    count_en,
    output div_op_t op
);

    typedef enum logic [1:0] {
        START   = 2'b00,
        PROCESS = 2'b01,
        WAIT    = 2'b10,
        DONE    = 2'b11
    } state_t;

    state_t state;
    state_t next_state;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= START;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state  = state;
        src_ready   = 1'b0;
        dest_valid  = 1'b0;
        count_clear = 1'b0;
        count_en    = 1'b0;
        op          = op_hold;
        case (state)
            START: begin
                src_ready   = 1'b1;
                count_clear = 1'b1;
                if (src_valid) begin
                    op         = op_load; // Operands captured on the accepting edge
                    next_state = PROCESS;
                end
            end
            PROCESS: begin
                count_en = 1'b1;
                // A borrow means the divisor does not fit, so the remainder is kept
                if (borrow) begin
                    op = op_shift_keep;
                end else begin
                    op = op_shift_sub;
                end
                if (last_step) begin
                    next_state = WAIT;
                end
            end
            WAIT: begin
                dest_valid = 1'b1;
                if (dest_ready) begin
                    next_state = DONE;
                end
            end
            DONE: begin
                next_state = START; // One idle cycle before the next operand pair
            end
            default: begin
                next_state = START;
            end
        endcase
    end

    a_no_overlap: assert property (
        @(posedge clk) disable iff (!rst)
        !(src_ready && dest_valid)
    );

    a_load_in_start: assert property (
        @(posedge clk) disable iff (!rst)
        (op == op_load) |-> (state == START)
    );

endmodule

// ==== verilog/div_step_counter.sv ====
`timescale 1ns/1ns
`include "div_settings.svh"

module div_step_counter (
    input  logic clk,
    input  logic rst,
    input  logic count_clear,
    input  logic count_en,
    output logic last_step
);

    localparam logic [`DIV_CNT_WIDTH-1:0] last_count = `DIV_CNT_WIDTH'(`DIV_WIDTH - 1);

    logic [`DIV_CNT_WIDTH-1:0] count;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            count <= '0;
        end else if (count_clear) begin
            count <= '0;
        end else if (count_en) begin
            count <= count + 1'b1;
        end
    end

    assign last_step = (count == last_count); // High during the final step

    // The controller must leave PROCESS once the final step is flagged
    a_count_range: assert property (
        @(posedge clk) disable iff (!rst)
        count_en |-> (count <= last_count)
    );

endmodule

// ==== verilog/div_datapath.sv ====
`timescale 1ns/1ns
`include "div_settings.svh"

module div_datapath import div_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  div_op_t       op,
    input  div_operands_t operands,
    output logic          borrow,
    output div_result_t   result
);

    logic [`DIV_WIDTH-1:0] divisor;
    div_rq_t               rq;
    div_rq_t               rq_next;
    logic [`DIV_WIDTH:0]   shift_rem;
    logic [`DIV_WIDTH:0]   diff;

    // Remainder after the shift, one bit wider so the trial never overflows
    assign shift_rem = rq.word[2*`DIV_WIDTH-1 -: `DIV_WIDTH+1];
    assign diff      = shift_rem - {1'b0, divisor};
    assign borrow    = diff[`DIV_WIDTH];

    always_comb begin
        rq_next = rq;
        case (op)
            op_load: begin
                rq_next.f.rem = '0;
                rq_next.f.quo = operands.dividend;
            end
            op_shift_sub: begin
                // Difference replaces the remainder, new quotient bit is 1
                rq_next.word = {diff[`DIV_WIDTH-1:0], rq.word[`DIV_WIDTH-2:0], 1'b1};
            end
            op_shift_keep: begin
                rq_next.word = {rq.word[2*`DIV_WIDTH-2:0], 1'b0};
            end
            default: begin
                rq_next = rq;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (op == op_load) begin
            divisor <= operands.divisor;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rq <= '0;
        end else begin
            rq <= rq_next;
        end
    end

    assign result.quotient  = rq.f.quo;
    assign result.remainder = rq.f.rem;

    a_hold_stable: assert property (
        @(posedge clk) disable iff (!rst)
        (op == op_hold) |=> $stable(rq.word)
    );

endmodule

// ==== verilog/div_top.sv ====
`timescale 1ns/1ns

module div_top import div_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          src_valid,
    input  div_operands_t src_data,
    output logic          src_ready,
    output logic          dest_valid,
    output div_result_t   dest_data,
    input  logic          dest_ready
);

    div_op_t op;
    logic    count_clear;
    logic    count_en;
    logic    last_step;
    logic    borrow;

    div_control u_control (
        .clk         (clk),
        .rst         (rst),
        .src_valid   (src_valid),
        .dest_ready  (dest_ready),
        .borrow      (borrow),
        .last_step   (last_step),
        .src_ready   (src_ready),
        .dest_valid  (dest_valid),
        .count_clear (count_clear),
        .count_en    (count_en),
        .op          (op)
    );

    div_step_counter u_counter (
        .clk         (clk),
        .rst         (rst),
        .count_clear (count_clear),
        .count_en    (count_en),
        .last_step   (last_step)
    );

    // Result register is held while the controller waits for dest_ready
    div_datapath u_datapath (
        .clk      (clk),
        .rst      (rst),
        .op       (op),
        .operands (src_data),
        .borrow   (borrow),
        .result   (dest_data)
    );

endmodule

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock (
    output logic clk,
    output logic rst
);

    localparam int half_period = 20;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    initial begin
        rst = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b1; // Released on the edge that ends the tenth cycle
    end

endmodule

// ==== tb/tb_div.sv ====
`timescale 1ns/1ns
`include "div_settings.svh"

module tb_div import div_pkg::*; ();

    localparam int w              = `DIV_WIDTH;
    localparam int num_edge       = 4;
    localparam int num_random     = 200;
    localparam int num_pressure   = 20;
    localparam int num_hold       = 20;
    localparam int max_gap        = 3;
    localparam int max_stall      = 12;
    localparam int timeout_cycles = (num_edge + num_random + num_pressure + num_hold)
                                    * (w + 2 + max_stall + max_gap + 4) + 10 + 100;

    typedef logic [w-1:0] word_t;

    logic          clk;
    logic          rst;
    logic          src_valid;
    div_operands_t src_data;
    logic          src_ready;
    logic          dest_valid;
    div_result_t   dest_data;
    logic          dest_ready;

    integer        seed        = 32'h66b9_3881;
    int            error_count = 0;
    int            check_count = 0;
    int            cycle_count = 0;
    int            divisions   = 0;
    int            accepts     = 0;
    int            results     = 0;
    int            errors_before;
    word_t         rand_a;
    word_t         rand_b;
    div_operands_t accepted; // Pair taken by the most recent source transfer

    tb_clock u_clock (
        .clk (clk),
        .rst (rst)
    );

    div_top u_dut (
        .clk        (clk),
        .rst        (rst),
        .src_valid  (src_valid),
        .src_data   (src_data),
        .src_ready  (src_ready),
        .dest_valid (dest_valid),
        .dest_data  (dest_data),
        .dest_ready (dest_ready)
    );

    // Restoring division by zero leaves all quotient bits set and the dividend as remainder
    function automatic div_result_t model_divide(input div_operands_t ops);
        div_result_t r;
        if (ops.divisor == '0) begin
            r.quotient  = '1;
            r.remainder = ops.dividend;
        end else begin
            r.quotient  = ops.dividend / ops.divisor;
            r.remainder = ops.dividend % ops.divisor;
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic report_test(input string name);
        $display("Test %s finished: %0d mismatches", name, error_count - errors_before);
    endtask

    // Entered and left at a falling edge with the DUT idle in START
    task automatic run_division(input string name, input word_t dividend, input word_t divisor,
                                input int stall_limit, input bit hold_valid);
        div_result_t expected;
        div_result_t held;
        int          stall;
        int          latency;
        repeat (($unsigned($random(seed)) % (max_gap + 1)) + 1) @(posedge clk);
        src_valid <= 1'b1;
        src_data  <= '{dividend: dividend, divisor: divisor};
        @(negedge clk);
        check_value({name, " src_ready"}, 1, src_ready);
        accepted = src_data;
        expected = model_divide(accepted);
        divisions++;
        @(posedge clk); // Accept edge
        if (hold_valid) begin
            // A second pair waits on the port for the whole division
            src_data <= '{dividend: word_t'($random(seed)), divisor: word_t'($random(seed))};
        end else begin
            src_valid <= 1'b0;
        end
        latency = 0;
        do begin
            @(negedge clk);
            if (!dest_valid) begin
                check_value({name, " src_ready while busy"}, 0, src_ready);
                @(posedge clk);
                latency++; // Edges passed since the accept edge
                dest_ready <= 1'($random(seed)); // Ignored until the result is offered
            end
        end while (!dest_valid);
        check_value({name, " latency"}, w, latency);
        check_value({name, " result"}, expected, dest_data);
        held  = dest_data;
        stall = $unsigned($random(seed)) % (stall_limit + 1);
        while (!dest_ready) begin
            @(posedge clk);
            if (stall == 0) begin
                dest_ready <= 1'b1;
            end
            stall--;
            @(negedge clk);
            check_value({name, " dest_valid held"}, 1, dest_valid);
            check_value({name, " dest_data held"}, held, dest_data);
            check_value({name, " src_ready while waiting"}, 0, src_ready);
        end
        @(posedge clk); // Result transfer edge
        dest_ready <= 1'($random(seed));
        @(negedge clk);
        check_value({name, " release src_ready"}, 0, src_ready);
        check_value({name, " release dest_valid"}, 0, dest_valid);
        @(posedge clk);
        src_valid <= 1'b0;
        @(negedge clk);
        check_value({name, " reopen src_ready"}, 1, src_ready);
    endtask

    always @(negedge clk) begin
        if (rst) begin
            if (src_valid && src_ready) accepts++;    // Transfer on the coming edge
            if (dest_valid && dest_ready) results++;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the run stopped after %0d cycles before the tests ended",
                     cycle_count);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        src_valid  = 1'b0;
        src_data   = '0;
        dest_ready = 1'b0;
        @(posedge rst);
        @(negedge clk);

        errors_before = error_count;
        check_value("reset_state src_ready", 1, src_ready);
        check_value("reset_state dest_valid", 0, dest_valid);
        report_test("reset_state");

        errors_before = error_count;
        run_division("divide_by_zero", word_t'($random(seed)), '0, 3, 1'b0);
        run_division("divide_by_one", word_t'($random(seed)), word_t'(1), 3, 1'b0);
        run_division("small_dividend", word_t'('1) >> 1, '1, 3, 1'b0);
        run_division("all_ones", '1, '1, 3, 1'b0);
        report_test("edge_operands");

        errors_before = error_count;
        repeat (num_random) begin
            rand_a = word_t'($random(seed));
            rand_b = word_t'($random(seed)) >> ($unsigned($random(seed)) % w);
            run_division("random_division", rand_a, rand_b, 3, 1'($random(seed)));
        end
        report_test("random_division");

        errors_before = error_count;
        repeat (num_pressure) begin
            rand_a = word_t'($random(seed));
            rand_b = word_t'($random(seed)) >> ($unsigned($random(seed)) % w);
            run_division("back_pressure", rand_a, rand_b, max_stall, 1'b0);
        end
        report_test("back_pressure");

        errors_before = error_count;
        repeat (num_hold) begin
            rand_a = word_t'($random(seed));
            rand_b = word_t'($random(seed)) >> ($unsigned($random(seed)) % w);
            run_division("no_early_accept", rand_a, rand_b, 3, 1'b1);
        end
        @(posedge clk);
        check_value("no_early_accept accepted pairs", divisions, accepts);
        check_value("no_early_accept result count", accepts, results);
        report_test("no_early_accept");

        $display("%0d divisions, %0d checks, %0d mismatches", divisions, check_count,
                 error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+verilog
verilog/div_pkg.sv
verilog/div_control.sv
verilog/div_step_counter.sv
verilog/div_datapath.sv
verilog/div_top.sv
tb/tb_clock.sv
tb/tb_div.sv

// ==== Makefile ====
LOG = sim.log

sim:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_div -Mdir obj_dir
	./obj_dir/Vtb_div | tee $(LOG)
	@grep -q "NO ERRORS" $(LOG)
	@! grep -q "ERRORS FOUND" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
